//--- hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // one fetch unit per hart
    localparam int NUM_HARTS = 4;

    // byte addresses on the bus and in the PC
    localparam int ADDR_WIDTH = 32;

    // AXI response code for a good read
    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // bus data word, also one instruction
    typedef logic [31:0] word_t;

    typedef logic [1:0] hart_id_t;

    // fetch unit FSM
    typedef enum logic [1:0] {
        idle,
        first_read,
        second_read,
        hold
    } fetch_state_t;

    // read arbiter FSM, one AXI read at a time
    typedef enum logic [1:0] {
        arb_idle,
        arb_addr,
        arb_data,
        arb_resp
    } arb_state_t;

endpackage

`default_nettype wire

//--- hw/pc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pc_sequencer (
    input  logic             clock,
    input  logic             reset,
    input  logic             redirect_valid [fetch_pkg::NUM_HARTS],
    input  fetch_pkg::addr_t redirect_pc    [fetch_pkg::NUM_HARTS],
    input  logic             pc_ready       [fetch_pkg::NUM_HARTS],
    output logic             pc_valid       [fetch_pkg::NUM_HARTS],
    output fetch_pkg::addr_t pc             [fetch_pkg::NUM_HARTS],
    output logic             flush          [fetch_pkg::NUM_HARTS]
);
    import fetch_pkg::*;

    // hart runs once it has seen a redirect
    logic [NUM_HARTS-1:0] active;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            active <= '0;
            for (int h = 0; h < NUM_HARTS; h++) begin
                flush[h] <= 1'b0;
            end
        end else begin
            for (int h = 0; h < NUM_HARTS; h++) begin
                // flush goes out together with the new PC
                flush[h] <= redirect_valid[h];
                if (redirect_valid[h]) begin
                    active[h] <= 1'b1;
                end
            end
        end
    end

    // program counters
    always_ff @(posedge clock) begin
        for (int h = 0; h < NUM_HARTS; h++) begin
            if (redirect_valid[h]) begin
                // redirect beats a same-cycle advance
                pc[h] <= redirect_pc[h];
            end else if (pc_valid[h] && pc_ready[h]) begin
                pc[h] <= pc[h] + addr_t'(4);
            end
        end
    end

    // offer a PC every cycle the hart is running
    always_comb begin
        for (int h = 0; h < NUM_HARTS; h++) begin
            pc_valid[h] = active[h];
        end
    end

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic             clock,
    input  logic             reset,
    input  logic             pc_valid,
    output logic             pc_ready,
    input  fetch_pkg::addr_t pc,
    input  logic             flush,
    output logic             req_valid,
    output fetch_pkg::addr_t req_addr,
    input  logic             req_grant,
    input  logic             rsp_valid,
    input  fetch_pkg::word_t rsp_data,
    input  logic             rsp_error,
    output logic             instr_valid,
    input  logic             instr_ready,
    output fetch_pkg::word_t instr,
    output fetch_pkg::addr_t instr_pc,
    output logic             instr_fault
);
    import fetch_pkg::*;

    fetch_state_t state;
    addr_t        pc_q;
    word_t        instr_q;
    logic         fault_q;
    // a granted read whose response has not come back yet
    logic         pending;
    // that read belongs to a flushed fetch
    logic         discard;
    logic [1:0]   offset;
    logic         rsp_take;

    assign offset   = pc_q[1:0];
    assign rsp_take = rsp_valid && pending && !discard && !flush;

    assign pc_ready  = (state == idle);
    assign req_valid = ((state == first_read) || (state == second_read)) && !pending;

    // word holding pc, then the word after it
    assign req_addr = (state == second_read) ? {pc_q[ADDR_WIDTH-1:2] + 1'b1, 2'b00}
                                             : {pc_q[ADDR_WIDTH-1:2], 2'b00};

    assign instr_valid = (state == hold);
    assign instr       = instr_q;
    assign instr_pc    = pc_q;
    assign instr_fault = fault_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pending <= 1'b0;
            discard <= 1'b0;
        end else begin
            if (req_grant) begin
                pending <= 1'b1;
            end else if (rsp_valid) begin
                pending <= 1'b0;
            end
            if (rsp_valid) begin
                discard <= 1'b0;
            end else if (flush && (pending || req_grant)) begin
                discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (pc_valid) begin
                        state <= first_read;
                    end
                end
                first_read: begin
                    if (flush) begin
                        state <= idle;
                    end else if (rsp_take) begin
                        state <= (offset == 2'd0) ? hold : second_read;
                    end
                end
                second_read: begin
                    if (flush) begin
                        state <= idle;
                    end else if (rsp_take) begin
                        state <= hold;
                    end
                end
                hold: begin
                    if (flush || instr_ready) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // instruction register, bytes shifted in from the bus words
    always_ff @(posedge clock) begin
        if ((state == idle) && pc_valid) begin
            pc_q <= pc;
        end
        if (rsp_take && (state == first_read)) begin
            // low bytes of the instruction from offset onward
            instr_q <= rsp_data >> {offset, 3'b000};
            fault_q <= rsp_error;
        end else if (rsp_take && (state == second_read)) begin
            case (offset)
                2'd1:    instr_q <= {rsp_data[ 7:0], instr_q[23:0]};
                2'd2:    instr_q <= {rsp_data[15:0], instr_q[15:0]};
                default: instr_q <= {rsp_data[23:0], instr_q[ 7:0]};
            endcase
            fault_q <= fault_q | rsp_error;
        end
    end

endmodule

`default_nettype wire

//--- hw/fetch_read_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_read_arbiter (
    input  logic             clock,
    input  logic             reset,
    input  logic             req_valid [fetch_pkg::NUM_HARTS],
    input  fetch_pkg::addr_t req_addr  [fetch_pkg::NUM_HARTS],
    output logic             req_grant [fetch_pkg::NUM_HARTS],
    output logic             rsp_valid [fetch_pkg::NUM_HARTS],
    output fetch_pkg::word_t rsp_data,
    output logic             rsp_error,
    output fetch_pkg::addr_t araddr,
    output logic             arvalid,
    input  logic             arready,
    output logic [2:0]       arprot,
    input  fetch_pkg::word_t rdata,
    input  logic [1:0]       rresp,
    input  logic             rvalid,
    output logic             rready
);
    import fetch_pkg::*;

    arb_state_t state;
    // last granted hart, search starts just after it
    hart_id_t   last_q;
    hart_id_t   owner_q;
    hart_id_t   pick;
    logic       found;
    word_t      rdata_q;
    logic       error_q;

    // round-robin choice
    always_comb begin
        hart_id_t cand;
        found = 1'b0;
        pick  = last_q;
        for (int i = 1; i <= NUM_HARTS; i++) begin
            cand = hart_id_t'(last_q + i);
            if (!found && req_valid[cand]) begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    always_comb begin
        for (int h = 0; h < NUM_HARTS; h++) begin
            req_grant[h] = (state == arb_idle) && found && (pick == hart_id_t'(h));
            rsp_valid[h] = (state == arb_resp) && (owner_q == hart_id_t'(h));
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state  <= arb_idle;
            last_q <= '0;
        end else begin
            case (state)
                arb_idle: begin
                    if (found) begin
                        last_q <= pick;
                        state  <= arb_addr;
                    end
                end
                arb_addr: begin
                    if (arready) begin
                        state <= arb_data;
                    end
                end
                arb_data: begin
                    if (rvalid) begin
                        state <= arb_resp;
                    end
                end
                default: begin
                    // arb_resp lasts one cycle
                    state <= arb_idle;
                end
            endcase
        end
    end

    // address and read data registers
    always_ff @(posedge clock) begin
        if ((state == arb_idle) && found) begin
            owner_q <= pick;
            araddr  <= req_addr[pick];
        end
        if ((state == arb_data) && rvalid) begin
            rdata_q <= rdata;
            error_q <= (rresp != RESP_OKAY);
        end
    end

    assign arvalid   = (state == arb_addr);
    assign rready    = (state == arb_data);
    // unprivileged, secure, data access
    assign arprot    = 3'b000;
    assign rsp_data  = rdata_q;
    assign rsp_error = error_q;

endmodule

`default_nettype wire

//--- hw/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic             clock,
    input  logic             reset,
    input  logic             redirect_valid [fetch_pkg::NUM_HARTS],
    input  fetch_pkg::addr_t redirect_pc    [fetch_pkg::NUM_HARTS],
    output logic             instr_valid    [fetch_pkg::NUM_HARTS],
    input  logic             instr_ready    [fetch_pkg::NUM_HARTS],
    output fetch_pkg::word_t instr          [fetch_pkg::NUM_HARTS],
    output fetch_pkg::addr_t instr_pc       [fetch_pkg::NUM_HARTS],
    output logic             instr_fault    [fetch_pkg::NUM_HARTS],
    output fetch_pkg::addr_t araddr,
    output logic             arvalid,
    input  logic             arready,
    output logic [2:0]       arprot,
    input  fetch_pkg::word_t rdata,
    input  logic [1:0]       rresp,
    input  logic             rvalid,
    output logic             rready
);
    import fetch_pkg::*;

    // sequencer to fetch units
    logic  pc_valid  [NUM_HARTS];
    logic  pc_ready  [NUM_HARTS];
    addr_t pc        [NUM_HARTS];
    logic  flush     [NUM_HARTS];

    // fetch units to arbiter
    logic  req_valid [NUM_HARTS];
    addr_t req_addr  [NUM_HARTS];
    logic  req_grant [NUM_HARTS];
    logic  rsp_valid [NUM_HARTS];
    word_t rsp_data;
    logic  rsp_error;

    pc_sequencer u_pc_sequencer (
        .clock          (clock),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pc_ready       (pc_ready),
        .pc_valid       (pc_valid),
        .pc             (pc),
        .flush          (flush)
    );

    for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hart
        fetch_unit u_fetch_unit (
            .clock       (clock),
            .reset       (reset),
            .pc_valid    (pc_valid[h]),
            .pc_ready    (pc_ready[h]),
            .pc          (pc[h]),
            .flush       (flush[h]),
            .req_valid   (req_valid[h]),
            .req_addr    (req_addr[h]),
            .req_grant   (req_grant[h]),
            .rsp_valid   (rsp_valid[h]),
            .rsp_data    (rsp_data),
            .rsp_error   (rsp_error),
            .instr_valid (instr_valid[h]),
            .instr_ready (instr_ready[h]),
            .instr       (instr[h]),
            .instr_pc    (instr_pc[h]),
            .instr_fault (instr_fault[h])
        );
    end

    // shared read data goes to every unit, rsp_valid picks the owner
    fetch_read_arbiter u_fetch_read_arbiter (
        .clock     (clock),
        .reset     (reset),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .req_grant (req_grant),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_error (rsp_error),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .arprot    (arprot),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready)
    );

endmodule

`default_nettype wire

//--- tests/fetch_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_assertions (
    input logic             clock,
    input logic             reset,
    input fetch_pkg::addr_t araddr,
    input logic             arvalid,
    input logic             arready,
    input logic             rready,
    input logic             instr_valid [fetch_pkg::NUM_HARTS],
    input logic             instr_ready [fetch_pkg::NUM_HARTS],
    input logic             flush       [fetch_pkg::NUM_HARTS]
);
    import fetch_pkg::*;

    // AR channel held until accepted
    ar_stable: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid or araddr changed before arready");

    ar_aligned: assert property (@(posedge clock) disable iff (reset)
        arvalid |-> (araddr[1:0] == 2'b00))
        else $error("araddr is not word aligned");

    ar_rise: assert property (@(posedge clock) disable iff (reset)
        $rose(arvalid) |-> !rready)
        else $error("arvalid rose while rready was high");

    for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hold
        instr_held: assert property (@(posedge clock) disable iff (reset)
            instr_valid[h] && !instr_ready[h] && !flush[h] |=> instr_valid[h])
            else $error("instr_valid dropped without handshake or flush");
    end

endmodule

bind fetch_top fetch_assertions u_fetch_assertions (
    .clock       (clock),
    .reset       (reset),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .arready     (arready),
    .rready      (rready),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .flush       (flush)
);

`default_nettype wire

//--- tests/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
    import fetch_pkg::*;

    localparam int MEM_WORDS = 256;
    localparam int MAX_CYCLES = 20000;

    logic  clock;
    logic  reset;
    logic  redirect_valid [NUM_HARTS];
    addr_t redirect_pc    [NUM_HARTS];
    logic  instr_valid    [NUM_HARTS];
    logic  instr_ready    [NUM_HARTS];
    word_t instr          [NUM_HARTS];
    addr_t instr_pc       [NUM_HARTS];
    logic  instr_fault    [NUM_HARTS];
    addr_t araddr;
    logic  arvalid;
    logic  arready;
    logic [2:0] arprot;
    word_t rdata;
    logic [1:0] rresp;
    logic  rvalid;
    logic  rready;

    word_t       mem [MEM_WORDS];
    logic [31:0] seed = 32'h7b2d;
    int          cycles = 0;
    // delivered instructions and next expected pc per hart
    int          count  [NUM_HARTS];
    addr_t       exp_pc [NUM_HARTS];

    fetch_top u_dut (.*);

    always #50 clock = ~clock;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // reads past the end of memory return zero
    function automatic word_t word_at(addr_t a);
        if (a >= 32'd1024) begin
            return 32'h0;
        end
        return mem[a[9:2]];
    endfunction

    function automatic logic [7:0] byte_at(addr_t a);
        word_t w;
        w = word_at({a[31:2], 2'b00});
        return w[{a[1:0], 3'b000} +: 8];
    endfunction

    function automatic word_t expected_instr(addr_t pc);
        return {byte_at(pc + 32'd3), byte_at(pc + 32'd2), byte_at(pc + 32'd1), byte_at(pc)};
    endfunction

    // either word read being out of range faults the instruction
    function automatic logic expected_fault(addr_t pc);
        addr_t w0;
        w0 = {pc[31:2], 2'b00};
        return (w0 >= 32'd1024) || ((pc[1:0] != 2'b00) && (w0 + 32'd4 >= 32'd1024));
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] expected, input string msg);
        if (got !== expected) begin
            $display("Mismatch at %0t: %s (got %h, expected %h)", $time, msg, got, expected);
            $display("Simulation failed");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic tick();
        @(posedge clock);
        #1;
    endtask

    task automatic wait_delivered(input int h, input int target);
        while (count[h] < target) begin
            tick();
        end
    endtask

    // stop the consumer, optionally wait for a held instruction, then redirect
    task automatic redirect_hart(input int h, input addr_t new_pc, input bit in_hold);
        instr_ready[h] = 1'b0;
        tick();
        while (in_hold && !instr_valid[h]) begin
            tick();
        end
        redirect_valid[h] = 1'b1;
        redirect_pc[h]    = new_pc;
        exp_pc[h]         = new_pc;
        tick();
        redirect_valid[h] = 1'b0;
        // flush cycle
        tick();
        instr_ready[h] = 1'b1;
    endtask

    // AXI4-Lite read slave with random arready and rvalid delays
    initial begin
        int    ms;
        int    delay;
        addr_t cap;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = 2'b00;
        ms      = 0;
        delay   = 0;
        cap     = '0;
        forever begin
            tick();
            case (ms)
                0: begin
                    if (arvalid && (delay == 0)) begin
                        check(32'(arprot), 32'd0, "arprot on the AR handshake");
                        arready = 1'b1;
                        cap     = araddr;
                        ms      = 1;
                    end else if (arvalid) begin
                        delay--;
                    end
                end
                1: begin
                    check(32'(rready), 32'd1, "rready after the AR handshake");
                    arready = 1'b0;
                    delay   = int'(lcg_next() % 32'd4);
                    ms      = 2;
                end
                2: begin
                    if (delay == 0) begin
                        rvalid = 1'b1;
                        rdata  = word_at(cap);
                        rresp  = (cap >= 32'd1024) ? 2'b10 : 2'b00;
                        ms     = 3;
                    end else begin
                        delay--;
                    end
                end
                default: begin
                    check(32'(rready), 32'd0, "rready after the R handshake");
                    rvalid = 1'b0;
                    delay  = int'(lcg_next() % 32'd4);
                    ms     = 0;
                end
            endcase
        end
    end

    // every accepted instruction is checked against memory and stream order
    always @(negedge clock) begin
        for (int h = 0; h < NUM_HARTS; h++) begin
            if (!reset && instr_valid[h] && instr_ready[h]) begin
                check(instr_pc[h], exp_pc[h], $sformatf("hart %0d instr_pc", h));
                check(32'(instr_fault[h]), 32'(expected_fault(exp_pc[h])),
                      $sformatf("hart %0d fault at pc %h", h, exp_pc[h]));
                if (!expected_fault(exp_pc[h])) begin
                    check(instr[h], expected_instr(exp_pc[h]),
                          $sformatf("hart %0d instr at pc %h", h, exp_pc[h]));
                end
                exp_pc[h] = exp_pc[h] + 32'd4;
                count[h]++;
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Simulation failed");
            $fatal(1, "timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    task automatic test_aligned();
        redirect_hart(0, 32'h40, 1'b0);
        wait_delivered(0, count[0] + 8);
    endtask

    task automatic test_unaligned();
        for (int off = 1; off < 4; off++) begin
            redirect_hart(0, 32'h80 + addr_t'(off), 1'b0);
            wait_delivered(0, count[0] + 3);
        end
    endtask

    task automatic test_concurrent();
        redirect_hart(0, 32'h200, 1'b0);
        redirect_hart(1, 32'h301, 1'b0);
        redirect_hart(2, 32'h0a2, 1'b0);
        redirect_hart(3, 32'h1f3, 1'b0);
        for (int h = 0; h < NUM_HARTS; h++) begin
            wait_delivered(h, count[h] + 10);
        end
    endtask

    task automatic test_redirect();
        // catch hart 1 with a granted read in flight
        while (!u_dut.g_hart[1].u_fetch_unit.pending) begin
            tick();
        end
        redirect_hart(1, 32'h50, 1'b0);
        wait_delivered(1, count[1] + 2);
        redirect_hart(1, 32'h66, 1'b1);
        wait_delivered(1, count[1] + 2);
    endtask

    task automatic test_bus_error();
        redirect_hart(3, 32'h400, 1'b0);
        wait_delivered(3, count[3] + 1);
        // second word at 0x400 is out of range
        redirect_hart(3, 32'h3fe, 1'b0);
        wait_delivered(3, count[3] + 2);
        redirect_hart(3, 32'h10, 1'b0);
        wait_delivered(3, count[3] + 2);
    endtask

    task automatic test_backpressure();
        int    hold_cycles;
        int    base0;
        int    base3;
        word_t held_instr;
        addr_t held_pc;
        instr_ready[2] = 1'b0;
        while (!instr_valid[2]) begin
            tick();
        end
        held_instr  = instr[2];
        held_pc     = instr_pc[2];
        base0       = count[0];
        base3       = count[3];
        hold_cycles = 60 + int'(lcg_next() % 32'd32);
        repeat (hold_cycles) begin
            tick();
            check(32'(instr_valid[2]), 32'd1, "hart 2 instr_valid under back-pressure");
            check(instr[2], held_instr, "hart 2 held instr");
            check(instr_pc[2], held_pc, "hart 2 held instr_pc");
        end
        check(32'(count[0] > base0), 32'd1, "hart 0 progress while hart 2 stalls");
        check(32'(count[3] > base3), 32'd1, "hart 3 progress while hart 2 stalls");
        instr_ready[2] = 1'b1;
        wait_delivered(2, count[2] + 2);
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        for (int h = 0; h < NUM_HARTS; h++) begin
            redirect_valid[h] = 1'b0;
            redirect_pc[h]    = '0;
            instr_ready[h]    = 1'b1;
            count[h]          = 0;
            exp_pc[h]         = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = lcg_next();
        end
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        tick();
        test_aligned();
        test_unaligned();
        test_concurrent();
        test_redirect();
        test_bus_error();
        test_backpressure();
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hw/fetch_pkg.sv
hw/pc_sequencer.sv
hw/fetch_unit.sv
hw/fetch_read_arbiter.sv
hw/fetch_top.sv
tests/fetch_assertions.sv
tests/fetch_tb.sv

//--- Makefile
# Verilator build and run of the fetch subsystem testbench

TOP := fetch_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
